//--- lorof_pht.f
+incdir+verification
logic/corep.sv
logic/pht_index_hash.sv
logic/pht_counter_bank.sv
logic/pht.sv
logic/pht_wrapper.sv
verification/pht_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the pht testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pht_tb -f lorof_pht.f -o pht_sim

out=$(./obj_dir/pht_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

//--- verification/pht_model.svh
// pht reference model
`ifndef PHT_MODEL_SVH
`define PHT_MODEL_SVH

// --------------------
// reference table
// --------------------

// expected counters, 512 sets of 8 lanes
pht_set_t model_tab [PHT_SETS];

// gshare set index
function automatic pht_idx_t hash_index(input fetch_idx_t fi, input GH_t gh, input ASID_t asid);
    pht_idx_t folded;
    // low 9 history bits against the top 3
    folded = gh[8:0] ^ {6'b000000, gh[11:9]};
    return folded ^ asid ^ {2'b00, fi};
endfunction

// 2-bit saturating count
function automatic pht_ctr_t ctr_next(input pht_ctr_t ctr, input logic taken);
    if (taken) begin
        if (ctr == 2'd3) begin
            return ctr;
        end
        return ctr + 2'd1;
    end
    if (ctr == 2'd0) begin
        return ctr;
    end
    return ctr - 2'd1;
endfunction

// every lane weakly not taken
function automatic void clear_table();
    for (int i = 0; i < PHT_SETS; i++) begin
        model_tab[i] = {FETCH_LANES{PHT_CTR_RESET}};
    end
endfunction

// one update, in presentation order
function automatic void apply_update(input pht_update_t up, input ASID_t asid);
    pht_idx_t idx;
    fetch_lane_t lane;
    idx = hash_index(up.pc38[9:3], up.gh, asid);
    lane = up.pc38[2:0];
    model_tab[idx][lane] = ctr_next(model_tab[idx][lane], up.taken);
endfunction

`endif

//--- verification/pht_tb.sv
// pht testbench
`timescale 1ns/100ps

module pht_tb;
    import corep::*;

    // phase lengths in cycles
    localparam int RESET_CYCLES = 5;
    localparam int READ_CYCLES = 40;
    localparam int DIRECTED_CYCLES = 51;
    localparam int RANDOM_CYCLES = 2000;
    localparam int DRAIN_CYCLES = 4;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + READ_CYCLES + DIRECTED_CYCLES
        + RANDOM_CYCLES + DRAIN_CYCLES + 50;

    logic CLK = 1'b0;
    logic nRST;
    ASID_t next_arch_asid;
    logic next_read_req_valid;
    fetch_idx_t next_read_req_fetch_index;
    GH_t next_read_req_gh;
    fetch_lane_t next_read_resp_redirect_lane;
    logic last_read_resp_taken;
    logic next_update_valid;
    PC38_t next_update_pc38;
    GH_t next_update_gh;
    logic next_update_taken;

    `include "pht_model.svh"

    logic [31:0] lfsr_state = 32'he91a_458d;
    ASID_t cur_asid;
    int unsigned cyc;
    int cycle_count = 0;

    // request waiting for its lane
    logic prev_valid;
    pht_set_t prev_set;
    // expected responses, indexed by cycle mod 4
    logic chk_valid [4];
    logic chk_val [4];

    pht_wrapper pht_wrapper_i (
        .CLK(CLK),
        .nRST(nRST),
        .next_arch_asid(next_arch_asid),
        .next_read_req_valid(next_read_req_valid),
        .next_read_req_fetch_index(next_read_req_fetch_index),
        .next_read_req_gh(next_read_req_gh),
        .next_read_resp_redirect_lane(next_read_resp_redirect_lane),
        .last_read_resp_taken(last_read_resp_taken),
        .next_update_valid(next_update_valid),
        .next_update_pc38(next_update_pc38),
        .next_update_gh(next_update_gh),
        .next_update_taken(next_update_taken)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the test did not finish", cycle_count);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic PC38_t make_pc(input fetch_idx_t fi, input fetch_lane_t lane);
        return {28'h5a3c91e, fi, lane};
    endfunction

    // --------------------
    // one clock cycle
    // --------------------

    task automatic run_cycle(input logic rd_valid, input pht_read_req_t rq,
            input fetch_lane_t lane, input logic upd_valid, input pht_update_t up);
        logic [1:0] slot;
        @(posedge CLK);
        next_arch_asid <= cur_asid;
        next_read_req_valid <= rd_valid;
        next_read_req_fetch_index <= rq.fetch_index;
        next_read_req_gh <= rq.gh;
        next_read_resp_redirect_lane <= lane;
        next_update_valid <= upd_valid;
        next_update_pc38 <= up.pc38;
        next_update_gh <= up.gh;
        next_update_taken <= up.taken;
        // this lane picks the counter of last cycle's request
        if (prev_valid) begin
            slot = 2'(cyc + 2);
            chk_valid[slot] = 1'b1;
            chk_val[slot] = prev_set[lane][1];
        end
        // read sees every earlier update, not this one
        prev_valid = rd_valid;
        if (rd_valid) begin
            prev_set = model_tab[hash_index(rq.fetch_index, rq.gh, cur_asid)];
        end
        if (upd_valid) begin
            apply_update(up, cur_asid);
        end
        @(negedge CLK);
        slot = 2'(cyc);
        if (chk_valid[slot]) begin
            assert (last_read_resp_taken === chk_val[slot]) else begin
                $display("CHECK FAILED last_read_resp_taken expected %h actual %h",
                    chk_val[slot], last_read_resp_taken);
                stop_with_failure();
            end
            chk_valid[slot] = 1'b0;
        end
        cyc++;
    endtask

    task automatic train(input PC38_t pc, input GH_t gh, input logic taken);
        pht_update_t up;
        up.pc38 = pc;
        up.gh = gh;
        up.taken = taken;
        run_cycle(1'b0, '0, 3'd0, 1'b1, up);
    endtask

    // request cycle, then lane cycle
    task automatic read_and_expect(input PC38_t pc, input GH_t gh, input logic exp_taken);
        pht_read_req_t rq;
        pht_set_t set_now;
        rq.fetch_index = pc[9:3];
        rq.gh = gh;
        set_now = model_tab[hash_index(rq.fetch_index, gh, cur_asid)];
        assert (set_now[pc[2:0]][1] == exp_taken) else begin
            $display("model counter for pc %h does not give the intended direction", pc);
            stop_with_failure();
        end
        run_cycle(1'b1, rq, 3'd0, 1'b0, '0);
        run_cycle(1'b0, '0, pc[2:0], 1'b0, '0);
    endtask

    // --------------------
    // test sequence
    // --------------------

    initial begin
        pht_read_req_t rq;
        pht_update_t up;
        PC38_t pc;
        GH_t gh;
        GH_t gh_alias;
        fetch_lane_t lane;
        logic uv;
        nRST <= 1'b0;
        next_arch_asid <= '0;
        next_read_req_valid <= 1'b0;
        next_read_req_fetch_index <= '0;
        next_read_req_gh <= '0;
        next_read_resp_redirect_lane <= '0;
        next_update_valid <= 1'b0;
        next_update_pc38 <= '0;
        next_update_gh <= '0;
        next_update_taken <= 1'b0;
        cur_asid = '0;
        cyc = 0;
        prev_valid = 1'b0;
        prev_set = '0;
        for (int i = 0; i < 4; i++) begin
            chk_valid[i] = 1'b0;
            chk_val[i] = 1'b0;
        end
        clear_table();
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        // fresh table predicts not taken everywhere
        for (int i = 0; i < READ_CYCLES; i++) begin
            rq.fetch_index = fetch_idx_t'(lfsr_bits(7));
            rq.gh = GH_t'(lfsr_bits(12));
            lane = fetch_lane_t'(lfsr_bits(3));
            run_cycle(1'b1, rq, lane, 1'b0, '0);
        end

        // saturation and hysteresis
        pc = make_pc(7'h15, 3'd3);
        gh = 12'h3a7;
        train(pc, gh, 1'b1);
        train(pc, gh, 1'b1);
        read_and_expect(pc, gh, 1'b1);
        train(pc, gh, 1'b1);
        train(pc, gh, 1'b0);
        read_and_expect(pc, gh, 1'b1);
        train(pc, gh, 1'b0);
        train(pc, gh, 1'b0);
        read_and_expect(pc, gh, 1'b0);

        // neighbour lanes untouched
        gh = 12'h0f0;
        train(make_pc(7'h40, 3'd5), gh, 1'b1);
        train(make_pc(7'h40, 3'd5), gh, 1'b1);
        for (int l = 0; l < FETCH_LANES; l++) begin
            read_and_expect(make_pc(7'h40, 3'(l)), gh, (l == 5));
        end

        // asid and history select other sets
        cur_asid = 9'h0a5;
        pc = make_pc(7'h2c, 3'd2);
        gh = 12'h51e;
        train(pc, gh, 1'b1);
        train(pc, gh, 1'b1);
        read_and_expect(pc, gh, 1'b1);
        cur_asid = 9'h13c;
        read_and_expect(pc, gh, 1'b0);
        cur_asid = 9'h0a5;
        read_and_expect(pc, gh ^ 12'h800, 1'b0);

        // aliasing fetch indices share training
        gh_alias = gh ^ 12'(7'h2c ^ 7'h11);
        assert (hash_index(7'h11, gh_alias, cur_asid) == hash_index(7'h2c, gh, cur_asid))
        else begin
            $display("chosen fetch indices do not map to one set");
            stop_with_failure();
        end
        train(make_pc(7'h11, 3'd6), gh_alias, 1'b1);
        train(make_pc(7'h11, 3'd6), gh_alias, 1'b1);
        read_and_expect(make_pc(7'h2c, 3'd6), gh, 1'b1);

        // back-to-back updates, read right after
        cur_asid = '0;
        pc = make_pc(7'h07, 3'd1);
        gh = 12'hc33;
        train(pc, gh, 1'b1);
        train(pc, gh, 1'b1);
        train(pc, gh, 1'b1);
        read_and_expect(pc, gh, 1'b1);
        train(pc, gh, 1'b0);
        train(pc, gh, 1'b0);
        read_and_expect(pc, gh, 1'b0);

        // random mix over a small hot region
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            if (lfsr_bits(5) == 0) begin
                cur_asid = ASID_t'(lfsr_bits(2));
            end
            rq.fetch_index = fetch_idx_t'(lfsr_bits(3));
            rq.gh = GH_t'(lfsr_bits(4));
            up.pc38 = '0;
            up.pc38[37:10] = 28'(lfsr_bits(28));
            up.pc38[5:0] = 6'(lfsr_bits(6));
            up.gh = GH_t'(lfsr_bits(4));
            // direction mostly follows pc parity
            up.taken = up.pc38[0] ^ (lfsr_bits(2) == 0);
            lane = fetch_lane_t'(lfsr_bits(3));
            uv = 1'(lfsr_bits(1));
            run_cycle(1'b1, rq, lane, uv, up);
        end

        // let the last responses come out
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            run_cycle(1'b0, '0, 3'd0, 1'b0, '0);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- logic/pht_wrapper.sv
// registered pht top level
`timescale 1ns/100ps

module pht_wrapper (
    input logic CLK,
    input logic nRST,

    // arch state
    input corep::ASID_t next_arch_asid,

    // read request stage
    input logic next_read_req_valid,
    input corep::fetch_idx_t next_read_req_fetch_index,
    input corep::GH_t next_read_req_gh,

    // read response stage
    input corep::fetch_lane_t next_read_resp_redirect_lane,
    output logic last_read_resp_taken,

    // update
    input logic next_update_valid,
    input corep::PC38_t next_update_pc38,
    input corep::GH_t next_update_gh,
    input logic next_update_taken
);
    import corep::*;

    // --------------------
    // core side signals
    // --------------------

    // arch state
    ASID_t arch_asid;

    // read request, grouped
    logic read_req_valid;
    pht_read_req_t read_req;

    // read response
    fetch_lane_t read_resp_redirect_lane;
    logic read_resp_taken;

    // update, grouped
    logic update_valid;
    pht_update_t update;

    // --------------------
    // core
    // --------------------

    pht pht_i (
        .CLK(CLK),
        .nRST(nRST),
        .arch_asid(arch_asid),
        .read_req_valid(read_req_valid),
        .read_req(read_req),
        .read_resp_redirect_lane(read_resp_redirect_lane),
        .read_resp_taken(read_resp_taken),
        .update_valid(update_valid),
        .update(update)
    );

    // --------------------
    // boundary registers
    // --------------------

    // one stage on every input, one on the prediction
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            arch_asid <= '0;
            read_req_valid <= 1'b0;
            read_req <= '0;
            read_resp_redirect_lane <= '0;
            last_read_resp_taken <= 1'b0;
            update_valid <= 1'b0;
            update <= '0;
        end else begin
            arch_asid <= next_arch_asid;

            // strobes pass through as-is
            read_req_valid <= next_read_req_valid;
            read_req.fetch_index <= next_read_req_fetch_index;
            read_req.gh <= next_read_req_gh;

            // lane arrives a cycle after its request
            read_resp_redirect_lane <= next_read_resp_redirect_lane;
            last_read_resp_taken <= read_resp_taken;

            update_valid <= next_update_valid;
            update.pc38 <= next_update_pc38;
            update.gh <= next_update_gh;
            update.taken <= next_update_taken;
        end
    end

endmodule

//--- logic/pht.sv
// gshare pattern history table
`timescale 1ns/100ps

module pht (
    input logic CLK,
    input logic nRST,

    // arch state
    input corep::ASID_t arch_asid,

    // read request stage
    input logic read_req_valid,
    input corep::pht_read_req_t read_req,

    // read response stage, one cycle after request
    input corep::fetch_lane_t read_resp_redirect_lane,
    output logic read_resp_taken,

    // update from branch resolution
    input logic update_valid,
    input corep::pht_update_t update
);
    import corep::*;

    // --------------------
    // signals
    // --------------------

    // read path
    pht_idx_t read_index;
    pht_set_t read_set;
    pht_ctr_t read_ctr;

    // update stage 1, lookup
    fetch_idx_t upd_fetch_index;
    fetch_lane_t upd_lane;
    pht_idx_t upd_index;

    // update stage 2, modify and write
    logic upd2_valid;
    pht_idx_t upd2_index;
    fetch_lane_t upd2_lane;
    logic upd2_taken;
    pht_set_t upd2_old_set;
    pht_ctr_t upd2_old_ctr;
    pht_ctr_t upd2_new_ctr;
    pht_set_t upd2_new_set;

    // --------------------
    // read path
    // --------------------

    pht_index_hash read_hash_i (
        .fetch_index(read_req.fetch_index),
        .gh(read_req.gh),
        .asid(arch_asid),
        .index(read_index)
    );

    // response cycle lane mux
    assign read_ctr = read_set[read_resp_redirect_lane];
    // counter msb is the direction
    assign read_resp_taken = read_ctr[$bits(pht_ctr_t)-1];

    // --------------------
    // update stage 1
    // --------------------

    // lane and block index straight out of the pc
    assign upd_lane = update.pc38[FETCH_LANE_BITS-1:0];
    assign upd_fetch_index = update.pc38[FETCH_LANE_BITS +: FETCH_IDX_BITS];

    pht_index_hash update_hash_i (
        .fetch_index(upd_fetch_index),
        .gh(update.gh),
        .asid(arch_asid),
        .index(upd_index)
    );

    // valid only
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            upd2_valid <= 1'b0;
        end else begin
            upd2_valid <= update_valid;
        end
    end

    // payload follows the valid
    always_ff @(posedge CLK) begin
        if (update_valid) begin
            upd2_index <= upd_index;
            upd2_lane <= upd_lane;
            upd2_taken <= update.taken;
        end
    end

    // --------------------
    // update stage 2
    // --------------------

    always_comb begin
        upd2_old_ctr = upd2_old_set[upd2_lane];
        upd2_new_ctr = upd2_old_ctr;
        if (upd2_taken) begin
            // count up, stick at strongly taken
            if (upd2_old_ctr != PHT_CTR_MAX) begin
                upd2_new_ctr = upd2_old_ctr + pht_ctr_t'(1);
            end
        end else begin
            // count down, stick at 0
            if (upd2_old_ctr != pht_ctr_t'(0)) begin
                upd2_new_ctr = upd2_old_ctr - pht_ctr_t'(1);
            end
        end
        // other lanes written back unchanged
        upd2_new_set = upd2_old_set;
        upd2_new_set[upd2_lane] = upd2_new_ctr;
    end

    // --------------------
    // counter storage
    // --------------------

    // port b bypass covers back-to-back updates to one set
    pht_counter_bank bank_i (
        .CLK(CLK),
        .nRST(nRST),
        .rd_a_en(read_req_valid),
        .rd_a_index(read_index),
        .rd_a_set(read_set),
        .rd_b_en(update_valid),
        .rd_b_index(upd_index),
        .rd_b_set(upd2_old_set),
        .wr_en(upd2_valid),
        .wr_index(upd2_index),
        .wr_set(upd2_new_set)
    );

    // x direction would train the counter either way
    a_update_taken_known: assert property (@(posedge CLK) disable iff (!nRST)
        update_valid |-> !$isunknown(update.taken));

endmodule

//--- logic/pht_counter_bank.sv
// pht counter set storage
`timescale 1ns/100ps

module pht_counter_bank (
    input logic CLK,
    input logic nRST,

    // port a, fetch side reads
    input logic rd_a_en,
    input corep::pht_idx_t rd_a_index,
    output corep::pht_set_t rd_a_set,

    // port b, update side reads
    input logic rd_b_en,
    input corep::pht_idx_t rd_b_index,
    output corep::pht_set_t rd_b_set,

    // write port
    input logic wr_en,
    input corep::pht_idx_t wr_index,
    input corep::pht_set_t wr_set
);
    import corep::*;

    // one counter set per index
    pht_set_t table_q [PHT_SETS];

    // set lookup with write-first bypass
    function automatic pht_set_t bypass_read(input pht_idx_t idx);
        if (wr_en && (wr_index == idx)) begin
            return wr_set;
        end
        return table_q[idx];
    endfunction

    // --------------------
    // table array
    // --------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // every lane weakly not taken
            for (int i = 0; i < PHT_SETS; i++) begin
                table_q[i] <= {FETCH_LANES{PHT_CTR_RESET}};
            end
        end else if (wr_en) begin
            table_q[wr_index] <= wr_set;
        end
    end

    // --------------------
    // read ports
    // --------------------

    // one cycle latency, held when not enabled
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_a_set <= {FETCH_LANES{PHT_CTR_RESET}};
            rd_b_set <= {FETCH_LANES{PHT_CTR_RESET}};
        end else begin
            if (rd_a_en) begin
                rd_a_set <= bypass_read(rd_a_index);
            end
            if (rd_b_en) begin
                rd_b_set <= bypass_read(rd_b_index);
            end
        end
    end

    // unknown index would corrupt an arbitrary set
    a_wr_index_known: assert property (@(posedge CLK) disable iff (!nRST)
        wr_en |-> !$isunknown(wr_index));

endmodule

//--- logic/pht_index_hash.sv
// pht set index hash
`timescale 1ns/100ps

module pht_index_hash (
    // fetch block within the page of blocks
    input corep::fetch_idx_t fetch_index,

    // global history at prediction time
    input corep::GH_t gh,

    // current address space
    input corep::ASID_t asid,

    // selected counter set
    output corep::pht_idx_t index
);
    import corep::*;

    // history bits above the index width
    localparam int GH_FOLD_BITS = GH_BITS - PHT_SET_BITS;

    // --------------------
    // history fold
    // --------------------

    // low history slice, already index wide
    pht_idx_t gh_low;

    // top history slice, zero-extended
    pht_idx_t gh_high;

    // folded history
    pht_idx_t gh_folded;

    // fetch index zero-extended
    pht_idx_t fetch_index_ext;

    assign gh_low = gh[PHT_SET_BITS-1:0];
    assign gh_high = {{(PHT_SET_BITS - GH_FOLD_BITS){1'b0}}, gh[GH_BITS-1 -: GH_FOLD_BITS]};
    assign gh_folded = gh_low ^ gh_high;

    // --------------------
    // asid and fetch index
    // --------------------

    assign fetch_index_ext = {{(PHT_SET_BITS - FETCH_IDX_BITS){1'b0}}, fetch_index};

    // asid is index wide, no extension
    // same xor chain feeds read and update lookups
    assign index = gh_folded ^ asid ^ fetch_index_ext;

endmodule

//--- logic/corep.sv
// core predictor shared types
package corep;

    // --------------------
    // address and history widths
    // --------------------

    localparam int PC38_BITS = 38;
    localparam int FETCH_LANE_BITS = 3;
    localparam int FETCH_IDX_BITS = 7;
    localparam int GH_BITS = 12;
    localparam int ASID_BITS = 9;

    // pc without its low bit
    typedef logic [PC38_BITS-1:0] PC38_t;
    // pc38[2:0]
    typedef logic [FETCH_LANE_BITS-1:0] fetch_lane_t;
    // pc38[9:3]
    typedef logic [FETCH_IDX_BITS-1:0] fetch_idx_t;
    typedef logic [GH_BITS-1:0] GH_t;
    typedef logic [ASID_BITS-1:0] ASID_t;

    // --------------------
    // pht geometry
    // --------------------

    localparam int PHT_SET_BITS = 9;
    localparam int PHT_SETS = 512;
    localparam int FETCH_LANES = 8;

    typedef logic [PHT_SET_BITS-1:0] pht_idx_t;

    // 2-bit saturating counter, msb set means taken
    typedef logic [1:0] pht_ctr_t;

    // weakly not taken
    localparam pht_ctr_t PHT_CTR_RESET = 2'd1;
    // strongly taken, saturation point
    localparam pht_ctr_t PHT_CTR_MAX = 2'd3;

    // one counter per lane of a fetch block
    typedef pht_ctr_t [FETCH_LANES-1:0] pht_set_t;

    // --------------------
    // request structs
    // --------------------

    typedef struct packed {
        fetch_idx_t fetch_index;
        GH_t gh;
    } pht_read_req_t;

    typedef struct packed {
        PC38_t pc38;
        GH_t gh;
        logic taken;
    } pht_update_t;

endpackage
